// ==== src/zipdbg_pkg.sv ====
// Debug data bus is fixed at 32 bits and every control bit sits in the low byte of the word
package zipdbg_pkg;

	////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////

	// Debug data width, AXI-lite only
	localparam int DBG_DATA_W   = 32;
	// Byte offset bits below the word index
	localparam int DBG_WORD_LSB = 2;

	typedef logic [DBG_DATA_W-1:0]   dbg_word_t;
	typedef logic [DBG_DATA_W/8-1:0] dbg_strb_t;
	// CPU register index, 32 registers
	typedef logic [4:0]              dbg_regsel_t;

	////////////////////////////////////////
	// Address map and bit positions
	////////////////////////////////////////

	// Word address bit, 0 for control and 1 for CPU registers
	localparam int ADDR_SPACE_BIT = 5;

	// Control register bits, same places in the status word
	localparam int HALT_BIT        = 0;
	localparam int HALTED_BIT      = 1;
	localparam int STEP_BIT        = 2;
	localparam int RESET_BIT       = 3;
	localparam int CLEAR_CACHE_BIT = 4;
	localparam int CATCH_BIT       = 5;

	// CPU flags in the status word
	localparam int ST_SLEEP_BIT = 8;
	localparam int ST_GIE_BIT   = 9;
	localparam int ST_INT_BIT   = 10;
	localparam int ST_BREAK_BIT = 11;

endpackage

// ==== src/dbg_req_if.sv ====
// Word addresses must be at least ADDR_SPACE_BIT+1 bits wide for the space select to exist
`timescale 1ns/1ps

interface dbg_req_if #(
	parameter int WA = 6
);
	import zipdbg_pkg::*;

	// Accepted write, valid for one cycle only
	logic            wr_ready;
	logic [WA-1:0]   wr_addr;
	dbg_word_t       wr_data;
	dbg_strb_t       wr_strb;
	// Accepted read, valid for one cycle only
	logic            rd_ready;
	logic [WA-1:0]   rd_addr;
	// Back-pressure from control and response sides
	logic            wr_stall;
	logic            b_free;
	logic            r_free;

	modport intake (output wr_ready, wr_addr, wr_data, wr_strb, rd_ready, rd_addr,
		input wr_stall, b_free, r_free);

	modport ctrl (input wr_ready, wr_addr, wr_data, wr_strb, output wr_stall);

	modport resp (input wr_ready, rd_ready, rd_addr, output b_free, r_free);

endinterface

// ==== src/dbg_skid.sv ====
// Zero-latency skid buffer with no output register, so o_valid and o_data are combinational
`timescale 1ns/1ps

module dbg_skid #(
	parameter int DW = 8
) (
	input  logic          S_AXI_ACLK,
	input  logic          S_AXI_ARESETN,
	input  logic          i_valid,
	output logic          o_ready,
	input  logic [DW-1:0] i_data,
	output logic          o_valid,
	input  logic          i_ready,
	output logic [DW-1:0] o_data
);

	// Side register, filled only when downstream stalls
	logic          r_valid;
	logic [DW-1:0] r_data;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Capture whatever is on the input while empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	assign o_ready = !r_valid;
	// Held entry goes first, else straight through
	assign o_valid = i_valid || r_valid;
	assign o_data  = r_valid ? r_data : i_data;

	// Offered entry holds still until downstream takes it
	a_skid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(o_valid && !i_ready) |=> (o_valid && $stable(o_data)));

endmodule

// ==== src/dbg_axil_intake.sv ====
// Byte address bits are dropped, so every access is treated as a full aligned word
`timescale 1ns/1ps

module dbg_axil_intake #(
	parameter int C_DBG_ADDR_WIDTH = 8
) (
	input  logic                        S_AXI_ACLK,
	input  logic                        S_AXI_ARESETN,
	input  logic                        i_awvalid,
	output logic                        o_awready,
	input  logic [C_DBG_ADDR_WIDTH-1:0] i_awaddr,
	input  logic                        i_wvalid,
	output logic                        o_wready,
	input  zipdbg_pkg::dbg_word_t       i_wdata,
	input  zipdbg_pkg::dbg_strb_t       i_wstrb,
	input  logic                        i_arvalid,
	output logic                        o_arready,
	input  logic [C_DBG_ADDR_WIDTH-1:0] i_araddr,
	dbg_req_if.intake                   req
);
	import zipdbg_pkg::*;

	localparam int WA  = C_DBG_ADDR_WIDTH - DBG_WORD_LSB;
	// Strobe rides along with the data
	localparam int WDW = DBG_DATA_W + DBG_DATA_W/8;

	logic           aw_valid, w_valid, ar_valid;
	logic [WA-1:0]  aw_addr, ar_addr;
	logic [WDW-1:0] w_in, w_out;
	dbg_word_t      w_data;
	dbg_strb_t      w_strb;
	logic           wr_accept, rd_accept;

	assign w_in = {i_wstrb, i_wdata};
	assign {w_strb, w_data} = w_out;

	dbg_skid #(.DW(WA)) awskd_i (.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(i_awvalid), .o_ready(o_awready), .i_data(i_awaddr[C_DBG_ADDR_WIDTH-1:DBG_WORD_LSB]),
		.o_valid(aw_valid), .i_ready(wr_accept), .o_data(aw_addr));

	dbg_skid #(.DW(WDW)) wskd_i (.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(i_wvalid), .o_ready(o_wready), .i_data(w_in),
		.o_valid(w_valid), .i_ready(wr_accept), .o_data(w_out));

	dbg_skid #(.DW(WA)) arskd_i (.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(i_arvalid), .o_ready(o_arready), .i_data(i_araddr[C_DBG_ADDR_WIDTH-1:DBG_WORD_LSB]),
		.o_valid(ar_valid), .i_ready(rd_accept), .o_data(ar_addr));

	// Both halves present and B free
	// Only a real CPU register write waits out a stall
	assign wr_accept = aw_valid && w_valid && req.b_free
		&& ((w_strb == '0) || !aw_addr[ADDR_SPACE_BIT] || !req.wr_stall);
	// One read at a time
	assign rd_accept = ar_valid && req.r_free;

	assign req.wr_ready = wr_accept;
	assign req.wr_addr  = aw_addr;
	assign req.wr_data  = w_data;
	assign req.wr_strb  = w_strb;
	assign req.rd_ready = rd_accept;
	assign req.rd_addr  = ar_addr;

endmodule

// ==== src/dbg_cpu_ctrl.sv ====
// RESET_DURATION must be at least 1, and a break resets the CPU unless catch is set
`timescale 1ns/1ps

module dbg_cpu_ctrl #(
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED   = 1'b1
) (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	dbg_req_if.ctrl                 req,
	input  logic                    i_cpu_reset,
	input  logic                    i_break,
	input  logic                    i_dbg_stall,
	output logic                    o_cmd_reset,
	output logic                    o_halt,
	output logic                    o_clear_cache,
	output logic                    o_step,
	output logic                    o_catch,
	output logic                    o_dbg_we,
	output zipdbg_pkg::dbg_regsel_t o_dbg_wreg,
	output zipdbg_pkg::dbg_word_t   o_dbg_wdata
);
	import zipdbg_pkg::*;

	localparam int CW = $clog2(RESET_DURATION + 1);

	logic          cmd_write, cpu_we;
	logic          reset_request, release_request, halt_request;
	logic          step_request, clear_cache_request;
	logic [CW-1:0] reset_counter;
	logic          reset_hold;

	////////////////////////////////////////
	// Command decode
	////////////////////////////////////////

	assign cmd_write = req.wr_ready && !req.wr_addr[ADDR_SPACE_BIT];
	// Only full-word writes reach a CPU register
	assign cpu_we    = req.wr_ready && (req.wr_strb == '1) && req.wr_addr[ADDR_SPACE_BIT];

	// Each bit counts only when its byte lane is strobed
	assign reset_request   = cmd_write && req.wr_strb[RESET_BIT/8] && req.wr_data[RESET_BIT];
	assign release_request = cmd_write && req.wr_strb[HALT_BIT/8] && !req.wr_data[HALT_BIT];
	assign halt_request    = cmd_write && req.wr_strb[HALT_BIT/8] && req.wr_data[HALT_BIT];
	assign step_request    = cmd_write && req.wr_strb[STEP_BIT/8] && req.wr_data[STEP_BIT];
	assign clear_cache_request = cmd_write && req.wr_strb[CLEAR_CACHE_BIT/8]
		&& req.wr_data[CLEAR_CACHE_BIT];

	////////////////////////////////////////
	// Reset hold and CPU reset
	////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
		begin
			reset_counter <= CW'(RESET_DURATION);
			reset_hold    <= 1'b1;
		end
		else
		begin
			if (reset_counter != '0)
				reset_counter <= reset_counter - 1'b1;
			// Drops one cycle ahead of the counter reaching zero
			reset_hold <= (reset_counter > 1);
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset || reset_hold)
			o_cmd_reset <= 1'b1;
		else if (i_break && !o_catch)
			o_cmd_reset <= 1'b1;
		else
			o_cmd_reset <= reset_request;
	end

	////////////////////////////////////////
	// Halt, step, clear-cache, catch
	////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_halt <= START_HALTED;
		else if (i_cpu_reset && !req.wr_ready && !req.wr_stall)
			o_halt <= START_HALTED;
		else
		begin
			// Release only once fully stopped, nothing pending
			if (!o_dbg_we && !i_dbg_stall && (release_request || step_request))
				o_halt <= 1'b0;
			// Later lines win over the release
			if (i_break && o_catch)
				o_halt <= 1'b1;
			if (halt_request && !step_request)
				o_halt <= 1'b1;
			if (cpu_we)
				o_halt <= 1'b1;
			// Step runs one cycle then stops again
			if (o_step)
				o_halt <= 1'b1;
			if (o_clear_cache || clear_cache_request)
				o_halt <= 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_step <= 1'b0;
		else if (step_request)
			o_step <= 1'b1;
		else if (!i_dbg_stall)
			o_step <= 1'b0;
	end

	// Needs halt and clear-cache in the same write
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || o_cmd_reset)
			o_clear_cache <= 1'b0;
		else if (clear_cache_request && halt_request)
			o_clear_cache <= 1'b1;
		else if (o_halt && !i_dbg_stall)
			o_clear_cache <= 1'b0;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_catch <= START_HALTED;
		else if (cmd_write && req.wr_strb[CATCH_BIT/8])
			o_catch <= req.wr_data[CATCH_BIT];
	end

	////////////////////////////////////////
	// CPU register write port
	////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_dbg_we <= 1'b0;
		else if (!req.wr_stall)
			o_dbg_we <= cpu_we;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!req.wr_stall)
		begin
			o_dbg_wreg  <= req.wr_addr[4:0];
			o_dbg_wdata <= req.wr_data;
		end
	end

	// Write held until the CPU stops stalling
	assign req.wr_stall = o_dbg_we && i_dbg_stall;

	// Counter and registered reset stay in step
	a_reset_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(reset_counter != '0) |-> o_cmd_reset);

endmodule

// ==== src/dbg_axil_resp.sv ====
// CPU register reads take two cycles and the core must answer o_dbg_rreg one cycle later
`timescale 1ns/1ps

module dbg_axil_resp (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	dbg_req_if.resp                 req,
	output logic                    o_bvalid,
	input  logic                    i_bready,
	output logic                    o_rvalid,
	input  logic                    i_rready,
	output zipdbg_pkg::dbg_word_t   o_rdata,
	output zipdbg_pkg::dbg_regsel_t o_dbg_rreg,
	input  zipdbg_pkg::dbg_word_t   i_dbg_rdata,
	input  logic                    i_dbg_stall,
	input  logic                    i_break,
	input  logic                    i_interrupt,
	input  logic [1:0]              i_dbg_cc,
	input  logic                    i_cmd_reset,
	input  logic                    i_halt,
	input  logic                    i_catch
);
	import zipdbg_pkg::*;

	dbg_word_t status;
	// CPU read waiting for the core's data
	logic      rd_cpu;

	// Status word, unused bits read as zero
	always_comb
	begin
		status                = '0;
		status[HALT_BIT]      = i_halt;
		status[HALTED_BIT]    = !i_dbg_stall;
		status[RESET_BIT]     = i_cmd_reset;
		status[CATCH_BIT]     = i_catch;
		status[ST_SLEEP_BIT]  = i_dbg_cc[0];
		status[ST_GIE_BIT]    = i_dbg_cc[1];
		status[ST_INT_BIT]    = i_interrupt;
		status[ST_BREAK_BIT]  = i_break;
	end

	// B channel
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (req.wr_ready)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

	assign req.b_free = !o_bvalid || i_bready;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_cpu <= 1'b0;
		else
			rd_cpu <= req.rd_ready && req.rd_addr[ADDR_SPACE_BIT];
	end

	// R channel, control reads answer at once
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (!o_rvalid || i_rready)
			o_rvalid <= (req.rd_ready && !req.rd_addr[ADDR_SPACE_BIT]) || rd_cpu;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_rvalid || i_rready)
			o_rdata <= rd_cpu ? i_dbg_rdata : status;
	end

	assign req.r_free = !rd_cpu && (!o_rvalid || i_rready);
	// Register index goes out on the accept cycle
	assign o_dbg_rreg = req.rd_addr[4:0];

	a_r_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(o_rvalid && !i_rready) |=> (o_rvalid && $stable(o_rdata)));

endmodule

// ==== src/zipdbg_top.sv ====
// AXI-lite only with no PROT ports, responses are always OKAY and the core attaches below
`timescale 1ns/1ps

module zipdbg_top #(
	parameter int C_DBG_ADDR_WIDTH = 8,
	parameter int RESET_DURATION   = 10,
	parameter bit START_HALTED     = 1'b1
) (
	input  logic                        S_AXI_ACLK,
	input  logic                        S_AXI_ARESETN,
	input  logic                        i_interrupt,
	input  logic                        i_cpu_reset,
	// Debug slave, AXI-lite
	input  logic                        i_s_dbg_awvalid,
	output logic                        o_s_dbg_awready,
	input  logic [C_DBG_ADDR_WIDTH-1:0] i_s_dbg_awaddr,
	input  logic                        i_s_dbg_wvalid,
	output logic                        o_s_dbg_wready,
	input  zipdbg_pkg::dbg_word_t       i_s_dbg_wdata,
	input  zipdbg_pkg::dbg_strb_t       i_s_dbg_wstrb,
	output logic                        o_s_dbg_bvalid,
	input  logic                        i_s_dbg_bready,
	output logic [1:0]                  o_s_dbg_bresp,
	input  logic                        i_s_dbg_arvalid,
	output logic                        o_s_dbg_arready,
	input  logic [C_DBG_ADDR_WIDTH-1:0] i_s_dbg_araddr,
	output logic                        o_s_dbg_rvalid,
	input  logic                        i_s_dbg_rready,
	output zipdbg_pkg::dbg_word_t       o_s_dbg_rdata,
	output logic [1:0]                  o_s_dbg_rresp,
	// CPU debug port
	output logic                        o_halt,
	output logic                        o_clear_cache,
	output logic                        o_step,
	output logic                        o_cmd_reset,
	output logic                        o_dbg_we,
	output zipdbg_pkg::dbg_regsel_t     o_dbg_wreg,
	output zipdbg_pkg::dbg_word_t       o_dbg_wdata,
	output zipdbg_pkg::dbg_regsel_t     o_dbg_rreg,
	input  zipdbg_pkg::dbg_word_t       i_dbg_rdata,
	input  logic                        i_dbg_stall,
	input  logic                        i_break,
	input  logic [1:0]                  i_dbg_cc
);
	import zipdbg_pkg::*;

	localparam int WA = C_DBG_ADDR_WIDTH - DBG_WORD_LSB;

	logic catch;

	dbg_req_if #(.WA(WA)) req ();

	dbg_axil_intake #(.C_DBG_ADDR_WIDTH(C_DBG_ADDR_WIDTH)) intake_i (.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_awvalid(i_s_dbg_awvalid), .o_awready(o_s_dbg_awready), .i_awaddr(i_s_dbg_awaddr),
		.i_wvalid(i_s_dbg_wvalid), .o_wready(o_s_dbg_wready),
		.i_wdata(i_s_dbg_wdata), .i_wstrb(i_s_dbg_wstrb),
		.i_arvalid(i_s_dbg_arvalid), .o_arready(o_s_dbg_arready), .i_araddr(i_s_dbg_araddr),
		.req(req.intake));

	dbg_cpu_ctrl #(.RESET_DURATION(RESET_DURATION), .START_HALTED(START_HALTED)) ctrl_i (
		.S_AXI_ACLK, .S_AXI_ARESETN, .req(req.ctrl),
		.i_cpu_reset, .i_break, .i_dbg_stall,
		.o_cmd_reset, .o_halt, .o_clear_cache, .o_step, .o_catch(catch),
		.o_dbg_we, .o_dbg_wreg, .o_dbg_wdata);

	dbg_axil_resp resp_i (.S_AXI_ACLK, .S_AXI_ARESETN, .req(req.resp),
		.o_bvalid(o_s_dbg_bvalid), .i_bready(i_s_dbg_bready),
		.o_rvalid(o_s_dbg_rvalid), .i_rready(i_s_dbg_rready), .o_rdata(o_s_dbg_rdata),
		.o_dbg_rreg, .i_dbg_rdata, .i_dbg_stall, .i_break, .i_interrupt, .i_dbg_cc,
		.i_cmd_reset(o_cmd_reset), .i_halt(o_halt), .i_catch(catch));

	// OKAY on every response
	assign o_s_dbg_bresp = 2'b00;
	assign o_s_dbg_rresp = 2'b00;

endmodule

// ==== dv/zipdbg_tb.sv ====
// CPU model answers register reads one cycle late and stalls one cycle after halt falls
`timescale 1ns/1ps

module zipdbg_tb;
	import zipdbg_pkg::*;

	localparam int RESET_DURATION = 10;
	localparam bit START_HALTED   = 1'b1;
	// Six tests, each well under 200 cycles
	localparam int MAX_CYCLES     = 2000;

	logic        S_AXI_ACLK;
	logic        S_AXI_ARESETN;
	logic        i_interrupt, i_cpu_reset;
	logic        i_s_dbg_awvalid, o_s_dbg_awready;
	logic [7:0]  i_s_dbg_awaddr;
	logic        i_s_dbg_wvalid, o_s_dbg_wready;
	dbg_word_t   i_s_dbg_wdata;
	dbg_strb_t   i_s_dbg_wstrb;
	logic        o_s_dbg_bvalid, i_s_dbg_bready;
	logic [1:0]  o_s_dbg_bresp;
	logic        i_s_dbg_arvalid, o_s_dbg_arready;
	logic [7:0]  i_s_dbg_araddr;
	logic        o_s_dbg_rvalid, i_s_dbg_rready;
	dbg_word_t   o_s_dbg_rdata;
	logic [1:0]  o_s_dbg_rresp;
	logic        o_halt, o_clear_cache, o_step, o_cmd_reset, o_dbg_we;
	dbg_regsel_t o_dbg_wreg, o_dbg_rreg;
	dbg_word_t   o_dbg_wdata, i_dbg_rdata;
	logic        i_dbg_stall, i_break;
	logic [1:0]  i_dbg_cc;

	int          cycle_count, error_count, check_count;
	logic [31:0] lcg_state;
	// CPU register file and the values written over the bus
	dbg_word_t   cpu_regs [32];
	dbg_word_t   shadow [32];
	// CPU model bookkeeping
	logic        halt_seen, halt_prev;
	dbg_regsel_t rreg_seen, last_wreg;
	dbg_word_t   last_wdata;
	int          we_count, halt_falls, halt_rises;
	int          step_count, clear_count;

	zipdbg_top #(
		.C_DBG_ADDR_WIDTH(8),
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(START_HALTED)
	) zipdbg_top_i (.*);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #4 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// Run limit
	initial
	begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES)
		begin
			@(posedge S_AXI_ACLK);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, a handshake never completed", cycle_count);
		$display("Some tests failed");
		$finish;
	end

	////////////////////////////////////////
	// CPU debug port model
	////////////////////////////////////////

	always @(posedge S_AXI_ACLK)
	begin
		halt_seen = o_halt;
		rreg_seen = o_dbg_rreg;
		// Write taken only while not stalled
		if ((o_dbg_we === 1'b1) && !i_dbg_stall)
		begin
			cpu_regs[o_dbg_wreg] = o_dbg_wdata;
			last_wreg  = o_dbg_wreg;
			last_wdata = o_dbg_wdata;
			we_count++;
		end
		if ((halt_prev === 1'b1) && (halt_seen === 1'b0))
			halt_falls++;
		if ((halt_prev === 1'b0) && (halt_seen === 1'b1))
			halt_rises++;
		halt_prev = halt_seen;
		// Step and clear-cache pulses seen by the core
		if (o_step === 1'b1)
			step_count++;
		if (o_clear_cache === 1'b1)
			clear_count++;
		#1;
		// Running means stalled from the debug side
		i_dbg_stall = (halt_seen === 1'b0);
		if (!$isunknown(rreg_seen))
			i_dbg_rdata = cpu_regs[rreg_seen];
	end

	////////////////////////////////////////
	// Helpers and compare tasks
	////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Byte address of CPU register idx
	function automatic logic [7:0] reg_addr(input dbg_regsel_t idx);
		return {1'b1, idx, 2'b00};
	endfunction

	function automatic dbg_word_t ctrl_word(input logic halt, input logic step,
		input logic catch_on);
		dbg_word_t w;
		w           = '0;
		w[HALT_BIT] = halt;
		w[STEP_BIT] = step;
		w[CATCH_BIT] = catch_on;
		return w;
	endfunction

	// Expected status with CPU flags all quiet
	function automatic dbg_word_t status_word(input logic halt, input logic halted,
		input logic catch_on);
		dbg_word_t w;
		w             = '0;
		w[HALT_BIT]   = halt;
		w[HALTED_BIT] = halted;
		w[CATCH_BIT]  = catch_on;
		return w;
	endfunction

	task automatic check_word(input string name, input dbg_word_t expected,
		input dbg_word_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("FAIL %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	// Stall level taken at the edge, after the model has settled
	task automatic wait_cpu_halted();
		logic halted;
		halted = 1'b0;
		while (!halted)
		begin
			@(posedge S_AXI_ACLK);
			halted = !i_dbg_stall;
			#1;
		end
	endtask

	task automatic wait_cpu_running();
		logic running;
		running = 1'b0;
		while (!running)
		begin
			@(posedge S_AXI_ACLK);
			running = i_dbg_stall;
			#1;
		end
	endtask

	////////////////////////////////////////
	// AXI-lite bus tasks
	////////////////////////////////////////

	// AW and W handshakes, each dropped once taken
	task automatic write_issue(input logic [7:0] addr, input dbg_word_t data,
		input dbg_strb_t strb);
		logic aw_done;
		logic w_done;
		aw_done         = 1'b0;
		w_done          = 1'b0;
		i_s_dbg_awaddr  = addr;
		i_s_dbg_awvalid = 1'b1;
		i_s_dbg_wdata   = data;
		i_s_dbg_wstrb   = strb;
		i_s_dbg_wvalid  = 1'b1;
		while (!aw_done || !w_done)
		begin
			@(posedge S_AXI_ACLK);
			if (i_s_dbg_awvalid && o_s_dbg_awready)
				aw_done = 1'b1;
			if (i_s_dbg_wvalid && o_s_dbg_wready)
				w_done = 1'b1;
			#1;
			if (aw_done)
				i_s_dbg_awvalid = 1'b0;
			if (w_done)
				i_s_dbg_wvalid = 1'b0;
		end
	endtask

	task automatic wait_bresp();
		logic done;
		done = 1'b0;
		while (!done)
		begin
			@(posedge S_AXI_ACLK);
			done = o_s_dbg_bvalid && i_s_dbg_bready;
			if (done)
				check_word("bresp okay", '0, dbg_word_t'(o_s_dbg_bresp));
			#1;
		end
	endtask

	task automatic axil_write(input logic [7:0] addr, input dbg_word_t data,
		input dbg_strb_t strb);
		i_s_dbg_bready = 1'b1;
		write_issue(addr, data, strb);
		wait_bresp();
	endtask

	task automatic read_issue(input logic [7:0] addr);
		logic done;
		done            = 1'b0;
		i_s_dbg_araddr  = addr;
		i_s_dbg_arvalid = 1'b1;
		while (!done)
		begin
			@(posedge S_AXI_ACLK);
			done = o_s_dbg_arready;
			#1;
		end
		i_s_dbg_arvalid = 1'b0;
	endtask

	// Data taken at the R handshake edge
	task automatic wait_rresp(output dbg_word_t data);
		logic done;
		done = 1'b0;
		data = '0;
		while (!done)
		begin
			@(posedge S_AXI_ACLK);
			done = o_s_dbg_rvalid && i_s_dbg_rready;
			if (done)
			begin
				data = o_s_dbg_rdata;
				check_word("rresp okay", '0, dbg_word_t'(o_s_dbg_rresp));
			end
			#1;
		end
	endtask

	task automatic axil_read(input logic [7:0] addr, output dbg_word_t data);
		i_s_dbg_rready = 1'b1;
		read_issue(addr);
		wait_rresp(data);
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic test_reset();
		int        high_cycles;
		dbg_word_t rd;
		high_cycles = 0;
		check_bit("reset bvalid", 1'b0, o_s_dbg_bvalid);
		check_bit("reset rvalid", 1'b0, o_s_dbg_rvalid);
		check_bit("reset halt", START_HALTED, o_halt);
		// Count cycles after release with CPU reset still forced
		while (high_cycles <= RESET_DURATION + 4)
		begin
			@(posedge S_AXI_ACLK);
			#1;
			if (!o_cmd_reset)
				break;
			high_cycles++;
		end
		check_word("reset hold cycles", dbg_word_t'(RESET_DURATION), dbg_word_t'(high_cycles));
		axil_read(8'h00, rd);
		check_word("reset status", status_word(1'b1, 1'b1, 1'b1), rd);
	endtask

	task automatic test_halt_release();
		dbg_word_t rd;
		axil_write(8'h00, ctrl_word(1'b0, 1'b0, 1'b1), 4'hf);
		axil_read(8'h00, rd);
		check_word("release status", status_word(1'b0, 1'b0, 1'b1), rd);
		axil_write(8'h00, ctrl_word(1'b1, 1'b0, 1'b1), 4'hf);
		axil_read(8'h00, rd);
		check_word("halt status", status_word(1'b1, 1'b1, 1'b1), rd);
	endtask

	task automatic test_register_access();
		dbg_regsel_t idx_list [8];
		dbg_regsel_t idx;
		dbg_word_t   data, rd;
		int          we_start;
		for (int k = 0; k < 8; k++)
		begin
			lcg_state = lcg_next(lcg_state);
			idx       = lcg_state[31:27];
			lcg_state = lcg_next(lcg_state);
			data      = lcg_state;
			we_start  = we_count;
			axil_write(reg_addr(idx), data, 4'hf);
			shadow[idx] = data;
			idx_list[k] = idx;
			check_word("register write count", dbg_word_t'(we_start + 1), dbg_word_t'(we_count));
			check_word("register write index", dbg_word_t'(idx), dbg_word_t'(last_wreg));
			check_word("register write data", data, last_wdata);
		end
		for (int k = 0; k < 8; k++)
		begin
			axil_read(reg_addr(idx_list[k]), rd);
			check_word("register read", shadow[idx_list[k]], rd);
		end
	endtask

	task automatic test_step();
		int        falls_start, rises_start, step_start, clear_start;
		dbg_word_t rd;
		falls_start = halt_falls;
		rises_start = halt_rises;
		step_start  = step_count;
		axil_write(8'h00, ctrl_word(1'b0, 1'b1, 1'b1), 4'hf);
		// Halt comes back on its own
		while (halt_rises == rises_start)
		begin
			@(posedge S_AXI_ACLK);
			#1;
		end
		check_word("step halt falls", dbg_word_t'(falls_start + 1), dbg_word_t'(halt_falls));
		check_word("step pulses", dbg_word_t'(step_start + 1), dbg_word_t'(step_count));
		check_bit("step halt again", 1'b1, o_halt);
		axil_read(8'h00, rd);
		check_word("step status", status_word(1'b1, 1'b1, 1'b1), rd);
		// Clear-cache with halt gives one pulse, CPU stays halted
		falls_start = halt_falls;
		clear_start = clear_count;
		axil_write(8'h00, ctrl_word(1'b1, 1'b0, 1'b1) | (dbg_word_t'(1) << CLEAR_CACHE_BIT),
			4'hf);
		@(posedge S_AXI_ACLK);
		#1;
		check_word("clear cache pulses", dbg_word_t'(clear_start + 1), dbg_word_t'(clear_count));
		check_bit("clear cache end", 1'b0, o_clear_cache);
		check_word("clear cache halt kept", dbg_word_t'(falls_start), dbg_word_t'(halt_falls));
	endtask

	task automatic test_break_policy();
		dbg_word_t rd;
		// Catch set, break halts
		axil_write(8'h00, ctrl_word(1'b0, 1'b0, 1'b1), 4'hf);
		wait_cpu_running();
		i_break = 1'b1;
		@(posedge S_AXI_ACLK);
		#1;
		i_break = 1'b0;
		check_bit("break catch halt", 1'b1, o_halt);
		check_bit("break catch no reset", 1'b0, o_cmd_reset);
		wait_cpu_halted();
		// Catch clear, break resets
		axil_write(8'h00, ctrl_word(1'b0, 1'b0, 1'b0), 4'hf);
		axil_read(8'h00, rd);
		check_word("break nocatch status", status_word(1'b0, 1'b0, 1'b0), rd);
		i_break = 1'b1;
		@(posedge S_AXI_ACLK);
		#1;
		i_break = 1'b0;
		check_bit("break reset pulse", 1'b1, o_cmd_reset);
		check_bit("break no halt", 1'b0, o_halt);
		@(posedge S_AXI_ACLK);
		#1;
		check_bit("break reset pulse end", 1'b0, o_cmd_reset);
		check_bit("break still running", 1'b0, o_halt);
		axil_write(8'h00, ctrl_word(1'b1, 1'b0, 1'b1), 4'hf);
		wait_cpu_halted();
	endtask

	task automatic test_back_pressure();
		dbg_regsel_t idx_a, idx_b;
		dbg_word_t   data_a, data_b, first, rd;
		int          we_start;
		// R held off
		i_s_dbg_rready = 1'b0;
		read_issue(8'h00);
		while (!o_s_dbg_rvalid)
		begin
			@(posedge S_AXI_ACLK);
			#1;
		end
		first = o_s_dbg_rdata;
		read_issue(reg_addr(5'd7));
		repeat (6)
		begin
			@(posedge S_AXI_ACLK);
			#1;
			check_bit("rstall rvalid", 1'b1, o_s_dbg_rvalid);
			check_word("rstall rdata", first, o_s_dbg_rdata);
			check_bit("rstall arready", 1'b0, o_s_dbg_arready);
		end
		i_s_dbg_rready = 1'b1;
		wait_rresp(rd);
		check_word("rstall first read", status_word(1'b1, 1'b1, 1'b1), rd);
		wait_rresp(rd);
		check_word("rstall second read", shadow[7], rd);
		// B held off
		lcg_state = lcg_next(lcg_state);
		idx_a     = lcg_state[31:27];
		idx_b     = idx_a ^ 5'd1;
		lcg_state = lcg_next(lcg_state);
		data_a    = lcg_state;
		lcg_state = lcg_next(lcg_state);
		data_b    = lcg_state;
		we_start  = we_count;
		i_s_dbg_bready = 1'b0;
		write_issue(reg_addr(idx_a), data_a, 4'hf);
		write_issue(reg_addr(idx_b), data_b, 4'hf);
		repeat (6)
		begin
			@(posedge S_AXI_ACLK);
			#1;
			check_bit("bstall bvalid", 1'b1, o_s_dbg_bvalid);
			check_bit("bstall awready", 1'b0, o_s_dbg_awready);
			check_bit("bstall wready", 1'b0, o_s_dbg_wready);
		end
		check_word("bstall write count", dbg_word_t'(we_start + 1), dbg_word_t'(we_count));
		i_s_dbg_bready = 1'b1;
		wait_bresp();
		wait_bresp();
		check_word("bstall both written", dbg_word_t'(we_start + 2), dbg_word_t'(we_count));
		shadow[idx_a] = data_a;
		shadow[idx_b] = data_b;
		axil_read(reg_addr(idx_a), rd);
		check_word("bstall read a", shadow[idx_a], rd);
		axil_read(reg_addr(idx_b), rd);
		check_word("bstall read b", shadow[idx_b], rd);
	endtask

	initial
	begin
		error_count     = 0;
		check_count     = 0;
		lcg_state       = 32'hc6f91a3d;
		we_count        = 0;
		halt_falls      = 0;
		halt_rises      = 0;
		step_count      = 0;
		clear_count     = 0;
		halt_prev       = 1'b1;
		S_AXI_ARESETN   = 1'b0;
		i_interrupt     = 1'b0;
		i_cpu_reset     = 1'b0;
		i_s_dbg_awvalid = 1'b0;
		i_s_dbg_awaddr  = '0;
		i_s_dbg_wvalid  = 1'b0;
		i_s_dbg_wdata   = '0;
		i_s_dbg_wstrb   = '0;
		i_s_dbg_bready  = 1'b1;
		i_s_dbg_arvalid = 1'b0;
		i_s_dbg_araddr  = '0;
		i_s_dbg_rready  = 1'b1;
		i_dbg_rdata     = '0;
		i_dbg_stall     = 1'b0;
		i_break         = 1'b0;
		i_dbg_cc        = 2'b00;
		// Register file fill from the full index
		for (int k = 0; k < 32; k++)
		begin
			cpu_regs[k] = 32'h5a5a0000 ^ (k * 32'h01010101);
			shadow[k]   = cpu_regs[k];
		end
		repeat (10) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;
		test_reset();
		test_halt_release();
		test_register_access();
		test_step();
		test_break_policy();
		test_back_pressure();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== all.f ====
src/zipdbg_pkg.sv
src/dbg_req_if.sv
src/dbg_skid.sv
src/dbg_axil_intake.sv
src/dbg_cpu_ctrl.sv
src/dbg_axil_resp.sv
src/zipdbg_top.sv
dv/zipdbg_tb.sv

// ==== Bender.yml ====
package:
  name: zipdbg

sources:
  - files:
      - src/zipdbg_pkg.sv
      - src/dbg_req_if.sv
      - src/dbg_skid.sv
      - src/dbg_axil_intake.sv
      - src/dbg_cpu_ctrl.sv
      - src/dbg_axil_resp.sv
      - src/zipdbg_top.sv
  - target: simulation
    files:
      - dv/zipdbg_tb.sv
